// ==== include/dprx_macros.svh ====
`ifndef DPRX_MACROS_SVH
`define DPRX_MACROS_SVH

// Symbols per lane per clock
`define DPRX_SPL 2

// K flag plus 8 data bits
`define DPRX_SYM_W 9

// History depth of the control symbol detectors, in cycles
`define DPRX_HIST 2

`endif

// ==== verilog/dprx_pkg.sv ====
`include "dprx_macros.svh"

package dprx_pkg;

    // Control symbols, K bit in the MSB
    typedef enum logic [`DPRX_SYM_W-1:0]
    {
        SYM_BS = 9'h1BC,
        SYM_SR = 9'h11C,
        SYM_BE = 9'h1FB,
        SYM_BF = 9'h17C,
        SYM_FS = 9'h1FE,
        SYM_FE = 9'h1F7,
        SYM_SS = 9'h15C,
        SYM_SE = 9'h1FD
    } dprx_sym_e;

    // One bit per sublane
    // Bit 0 holds the earlier symbol of the cycle
    typedef logic [`DPRX_SPL-1:0] sl_flags_t;

endpackage

// ==== verilog/dprx_sym_detect.sv ====
`timescale 1ns/1ps
`include "dprx_macros.svh"

module dprx_sym_detect
    import dprx_pkg::*;
(
    input  logic                                 CLK_IN,
    input  logic                                 RST_IN,
    input  logic                                 lnk_lock,
    input  logic                                 ctl_efm,
    input  sl_flags_t                            lnk_k,
    input  logic [`DPRX_SPL-1:0][`DPRX_SYM_W-2:0] lnk_dat,
    output logic                                 lock,
    output logic                                 efm,
    output sl_flags_t                            be,
    output sl_flags_t                            be_fe,
    output sl_flags_t                            bs,
    output sl_flags_t                            bf,
    output sl_flags_t                            fs,
    output sl_flags_t                            ss,
    output sl_flags_t                            se,
    output sl_flags_t                            be_fe_d1,
    output sl_flags_t                            bs_fs_d1,
    output sl_flags_t                            bs_d1,
    output sl_flags_t                            bs_d2,
    output sl_flags_t                            bf_d1,
    output sl_flags_t                            bf_d2,
    output sl_flags_t                            ss_d1,
    output sl_flags_t                            ss_d2,
    output sl_flags_t                            se_d1
);

    logic [`DPRX_SYM_W-1:0] sym [`DPRX_SPL];
    sl_flags_t              bs_hist [`DPRX_HIST];
    sl_flags_t              bf_hist [`DPRX_HIST];
    sl_flags_t              ss_hist [`DPRX_HIST];

    // Lock and framing mode into the clock domain of the parser
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            lock <= 1'b0;
            efm  <= 1'b0;
        end
        else
        begin
            lock <= lnk_lock;
            efm  <= ctl_efm;
        end
    end

    // Symbol decode per sublane
    always_comb
    begin
        for (int i = 0; i < `DPRX_SPL; i++)
        begin
            sym[i]   = {lnk_k[i], lnk_dat[i]};
            be[i]    = (sym[i] == SYM_BE);
            be_fe[i] = (sym[i] == SYM_BE) || (sym[i] == SYM_FE);
            // SR counts as a blanking start as well
            bs[i]    = (sym[i] == SYM_BS) || (sym[i] == SYM_SR);
            bf[i]    = (sym[i] == SYM_BF);
            fs[i]    = (sym[i] == SYM_FS);
            ss[i]    = (sym[i] == SYM_SS);
            se[i]    = (sym[i] == SYM_SE);
        end
    end

    // Detector history
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
        begin
            be_fe_d1 <= '0;
            bs_fs_d1 <= '0;
            se_d1    <= '0;
            for (int i = 0; i < `DPRX_HIST; i++)
            begin
                bs_hist[i] <= '0;
                bf_hist[i] <= '0;
                ss_hist[i] <= '0;
            end
        end
        else
        begin
            be_fe_d1   <= be_fe;
            bs_fs_d1   <= bs | fs;
            se_d1      <= se;
            bs_hist[0] <= bs;
            bf_hist[0] <= bf;
            ss_hist[0] <= ss;
            for (int i = 1; i < `DPRX_HIST; i++)
            begin
                bs_hist[i] <= bs_hist[i-1];
                bf_hist[i] <= bf_hist[i-1];
                ss_hist[i] <= ss_hist[i-1];
            end
        end
    end

    assign bs_d1 = bs_hist[0];
    assign bs_d2 = bs_hist[1];
    assign bf_d1 = bf_hist[0];
    assign bf_d2 = bf_hist[1];
    assign ss_d1 = ss_hist[0];
    assign ss_d2 = ss_hist[1];

    // A packet never ends on the symbol right after SS
    a_ss_se_excl: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        lock |-> ((se & {ss[0], ss_d1[1]}) == '0));

endmodule

// ==== verilog/dprx_vid_track.sv ====
`timescale 1ns/1ps

module dprx_vid_track
    import dprx_pkg::*;
(
    input  logic      CLK_IN,
    input  logic      RST_IN,
    input  logic      lock,
    input  sl_flags_t be_fe,
    input  sl_flags_t be_fe_d1,
    input  sl_flags_t bs,
    input  sl_flags_t fs,
    input  sl_flags_t bs_fs_d1,
    output sl_flags_t vid
);

    // Video active between BE/FE and the next BS, SR or FS
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            vid <= '0;
        else if (!lock)
            vid <= '0;
        else
        begin
            // Sublane 0, preceded by sublane 1 of the last cycle
            if (bs[0] || fs[0] || bs_fs_d1[1])
                vid[0] <= 1'b0;
            else if (be_fe_d1[0] || be_fe_d1[1])
                vid[0] <= 1'b1;

            // Sublane 1, preceded by sublane 0 of this cycle
            if (bs[0] || fs[0] || bs[1] || fs[1])
                vid[1] <= 1'b0;
            else if (be_fe[0] || be_fe_d1[1])
                vid[1] <= 1'b1;
        end
    end

    // BE and FE themselves are never video
    a_vid_unlock: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        lock |=> ((vid & $past(be_fe)) == '0));

endmodule

// ==== verilog/dprx_sdp_track.sv ====
`timescale 1ns/1ps

module dprx_sdp_track
    import dprx_pkg::*;
(
    input  logic      CLK_IN,
    input  logic      RST_IN,
    input  logic      lock,
    input  sl_flags_t ss,
    input  sl_flags_t ss_d1,
    input  sl_flags_t ss_d2,
    input  sl_flags_t se,
    input  sl_flags_t se_d1,
    output sl_flags_t msa,
    output sl_flags_t sec
);

    logic msa_start0;
    logic msa_start1;
    logic sec_start0;
    logic sec_start1;

    // SS SS in one cycle, or split over sublane 1 and the next sublane 0
    assign msa_start0 = (ss == 2'b00) &&
                        (((ss_d1 == 2'b11) && (ss_d2 == 2'b00)) ||
                         ((ss_d1 == 2'b01) && (ss_d2 == 2'b10)));
    assign msa_start1 = ((ss == 2'b00) && (ss_d1 == 2'b11) && (ss_d2 == 2'b00)) ||
                        ((ss == 2'b01) && (ss_d1 == 2'b10) && (ss_d2 == 2'b00));

    // Lone SS, not followed or preceded by another SS
    assign sec_start0 = (ss == 2'b00) && (ss_d2 == 2'b00) &&
                        ((ss_d1 == 2'b01) || (ss_d1 == 2'b10));
    assign sec_start1 = (ss_d2 == 2'b00) &&
                        (((ss == 2'b01) && (ss_d1 == 2'b00)) ||
                         ((ss == 2'b00) && (ss_d1 == 2'b10)));

    // MSA packet
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            msa <= '0;
        else if (!lock)
            msa <= '0;
        else
        begin
            if (se[0] || se_d1[1])
                msa[0] <= 1'b0;
            else if (msa_start0)
                msa[0] <= 1'b1;

            if (se[0] || se[1])
                msa[1] <= 1'b0;
            else if (msa_start1)
                msa[1] <= 1'b1;
        end
    end

    // Secondary data packet
    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            sec <= '0;
        else if (!lock)
            sec <= '0;
        else
        begin
            if (se[0] || se_d1[1])
                sec[0] <= 1'b0;
            else if (sec_start0)
                sec[0] <= 1'b1;

            if (se[0] || se[1])
                sec[1] <= 1'b0;
            else if (sec_start1)
                sec[1] <= 1'b1;
        end
    end

    // A symbol belongs to one packet kind at most
    a_msa_sec_excl: assert property (@(posedge CLK_IN) disable iff (RST_IN)
        (msa & sec) == '0);

endmodule

// ==== verilog/dprx_blank_decode.sv ====
`timescale 1ns/1ps

module dprx_blank_decode
    import dprx_pkg::*;
(
    input  logic      CLK_IN,
    input  logic      RST_IN,
    input  logic      lock,
    input  logic      efm,
    input  sl_flags_t bs,
    input  sl_flags_t bs_d1,
    input  sl_flags_t bs_d2,
    input  sl_flags_t bf,
    input  sl_flags_t bf_d1,
    input  sl_flags_t bf_d2,
    output sl_flags_t vbid,
    output sl_flags_t eol
);

    logic vbid_nxt0;
    logic vbid_nxt1;

    // VB-ID follows the blanking start
    always_comb
    begin
        if (efm)
        begin
            // BS BF over the cycle before last, BF BS over the last cycle
            vbid_nxt0 = (bs_d2 == 2'b01) && (bf_d2 == 2'b10) &&
                        (bs_d1 == 2'b10) && (bf_d1 == 2'b01);
            // BS in sublane 1, BF BF, BS in sublane 0 of this cycle
            vbid_nxt1 = (bs_d2 == 2'b10) && (bf_d1 == 2'b11) && (bs == 2'b01);
        end
        else
        begin
            vbid_nxt0 = (bs_d1 == 2'b10);
            vbid_nxt1 = (bs == 2'b01);
        end
    end

    always_ff @(posedge CLK_IN or posedge RST_IN)
    begin
        if (RST_IN)
            vbid <= '0;
        else if (!lock)
            vbid <= '0;
        else
            vbid <= {vbid_nxt1, vbid_nxt0};
    end

    // End of line on the last symbol before the blanking start
    // These refer to the symbols of the previous cycle
    always_comb
    begin
        eol = '0;
        if (lock)
        begin
            if (efm)
            begin
                eol[0] = (bs_d1 == 2'b10) && (bf == 2'b11);
                eol[1] = (bs == 2'b01) && (bf == 2'b10);
            end
            else
            begin
                eol[0] = (bs_d1 == 2'b10);
                eol[1] = (bs == 2'b01);
            end
        end
    end

endmodule

// ==== verilog/dprx_parser.sv ====
`timescale 1ns/1ps
`include "dprx_macros.svh"

module dprx_parser
    import dprx_pkg::*;
(
    input  logic                                 CLK_IN,
    input  logic                                 RST_IN,
    input  logic                                 ctl_efm,
    input  logic                                 lnk_lock,
    input  sl_flags_t                            lnk_k,
    input  logic [`DPRX_SPL-1:0][`DPRX_SYM_W-2:0] lnk_dat,
    output sl_flags_t                            src_k,
    output logic [`DPRX_SPL-1:0][`DPRX_SYM_W-2:0] src_dat,
    output logic                                 src_lock,
    output sl_flags_t                            src_sol,
    output sl_flags_t                            src_eol,
    output sl_flags_t                            src_vid,
    output sl_flags_t                            src_sec,
    output sl_flags_t                            src_msa,
    output sl_flags_t                            src_vbid
);

    logic      lock;
    logic      efm;
    sl_flags_t be;
    sl_flags_t be_fe;
    sl_flags_t bs;
    sl_flags_t bf;
    sl_flags_t fs;
    sl_flags_t ss;
    sl_flags_t se;
    sl_flags_t be_fe_d1;
    sl_flags_t bs_fs_d1;
    sl_flags_t bs_d1;
    sl_flags_t bs_d2;
    sl_flags_t bf_d1;
    sl_flags_t bf_d2;
    sl_flags_t ss_d1;
    sl_flags_t ss_d2;
    sl_flags_t se_d1;

    dprx_sym_detect sym_detect0 (
        .CLK_IN   (CLK_IN),
        .RST_IN   (RST_IN),
        .lnk_lock (lnk_lock),
        .ctl_efm  (ctl_efm),
        .lnk_k    (lnk_k),
        .lnk_dat  (lnk_dat),
        .lock     (lock),
        .efm      (efm),
        .be       (be),
        .be_fe    (be_fe),
        .bs       (bs),
        .bf       (bf),
        .fs       (fs),
        .ss       (ss),
        .se       (se),
        .be_fe_d1 (be_fe_d1),
        .bs_fs_d1 (bs_fs_d1),
        .bs_d1    (bs_d1),
        .bs_d2    (bs_d2),
        .bf_d1    (bf_d1),
        .bf_d2    (bf_d2),
        .ss_d1    (ss_d1),
        .ss_d2    (ss_d2),
        .se_d1    (se_d1)
    );

    dprx_vid_track vid_track0 (
        .CLK_IN   (CLK_IN),
        .RST_IN   (RST_IN),
        .lock     (lock),
        .be_fe    (be_fe),
        .be_fe_d1 (be_fe_d1),
        .bs       (bs),
        .fs       (fs),
        .bs_fs_d1 (bs_fs_d1),
        .vid      (src_vid)
    );

    dprx_sdp_track sdp_track0 (
        .CLK_IN (CLK_IN),
        .RST_IN (RST_IN),
        .lock   (lock),
        .ss     (ss),
        .ss_d1  (ss_d1),
        .ss_d2  (ss_d2),
        .se     (se),
        .se_d1  (se_d1),
        .msa    (src_msa),
        .sec    (src_sec)
    );

    dprx_blank_decode blank_decode0 (
        .CLK_IN (CLK_IN),
        .RST_IN (RST_IN),
        .lock   (lock),
        .efm    (efm),
        .bs     (bs),
        .bs_d1  (bs_d1),
        .bs_d2  (bs_d2),
        .bf     (bf),
        .bf_d1  (bf_d1),
        .bf_d2  (bf_d2),
        .vbid   (src_vbid),
        .eol    (src_eol)
    );

    // Symbols pass straight through
    assign src_k    = lnk_k;
    assign src_dat  = lnk_dat;
    assign src_lock = lock;

    // Start of line sits on the BE symbol itself
    assign src_sol  = be;

endmodule

// ==== testbench/tb_dprx_parser.sv ====
`timescale 1ns/1ps
`include "dprx_macros.svh"

module tb_dprx_parser
    import dprx_pkg::*;
();

    logic                                  CLK_IN;
    logic                                  RST_IN;
    logic                                  ctl_efm;
    logic                                  lnk_lock;
    sl_flags_t                             lnk_k;
    logic [`DPRX_SPL-1:0][`DPRX_SYM_W-2:0] lnk_dat;
    sl_flags_t                             src_k;
    logic [`DPRX_SPL-1:0][`DPRX_SYM_W-2:0] src_dat;
    logic                                  src_lock;
    sl_flags_t                             src_sol;
    sl_flags_t                             src_eol;
    sl_flags_t                             src_vid;
    sl_flags_t                             src_sec;
    sl_flags_t                             src_msa;
    sl_flags_t                             src_vbid;

    // One entry per clock cycle
    int          vec_test[$];
    logic        vec_lock[$];
    logic        vec_efm[$];
    sl_flags_t   vec_k[$];
    logic [7:0]  vec_d0[$];
    logic [7:0]  vec_d1[$];
    // Expected lock, sol, eol, vid, sec, msa, vbid from MSB down
    logic [12:0] vec_exp[$];

    logic [15:0] lfsr = 16'd39640;
    logic        load_ok = 1'b1;
    logic        load_done = 1'b0;
    logic        failed = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    dprx_parser dut0 (
        .CLK_IN   (CLK_IN),
        .RST_IN   (RST_IN),
        .ctl_efm  (ctl_efm),
        .lnk_lock (lnk_lock),
        .lnk_k    (lnk_k),
        .lnk_dat  (lnk_dat),
        .src_k    (src_k),
        .src_dat  (src_dat),
        .src_lock (src_lock),
        .src_sol  (src_sol),
        .src_eol  (src_eol),
        .src_vid  (src_vid),
        .src_sec  (src_sec),
        .src_msa  (src_msa),
        .src_vbid (src_vbid)
    );

    initial
    begin
        CLK_IN = 1'b0;
        forever
            #5 CLK_IN = ~CLK_IN;
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++)
        begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic data_field(input string s, output logic [7:0] b);
        int n;
        if (s == "rr")
            random_byte(b);
        else
        begin
            n = $sscanf(s, "%h", b);
            if (n != 1)
            begin
                $display("bad data field in the test data file: %s", s);
                load_ok = 1'b0;
            end
        end
    endtask

    task automatic load_vectors();
        int         fd;
        int         nf;
        int         tnum;
        string      line;
        string      d0_s;
        string      d1_s;
        logic       lk;
        logic       ef;
        logic [1:0] k;
        logic [7:0] d0;
        logic [7:0] d1;
        logic       x_lock;
        logic [1:0] x_sol;
        logic [1:0] x_eol;
        logic [1:0] x_vid;
        logic [1:0] x_sec;
        logic [1:0] x_msa;
        logic [1:0] x_vbid;
        fd = $fopen("testbench/dprx_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file testbench/dprx_testdata.txt");
            load_ok = 1'b0;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                // Blank lines and comments
                if (line.len() < 2 || line[0] == "#")
                    continue;
                nf = $sscanf(line, "%d %b %b %b %s %s %b %b %b %b %b %b %b",
                             tnum, lk, ef, k, d0_s, d1_s, x_lock, x_sol, x_eol,
                             x_vid, x_sec, x_msa, x_vbid);
                if (nf != 13)
                begin
                    $display("malformed line in the test data file: %s", line);
                    load_ok = 1'b0;
                end
                else
                begin
                    data_field(d0_s, d0);
                    data_field(d1_s, d1);
                    vec_test.push_back(tnum);
                    vec_lock.push_back(lk);
                    vec_efm.push_back(ef);
                    vec_k.push_back(k);
                    vec_d0.push_back(d0);
                    vec_d1.push_back(d1);
                    vec_exp.push_back({x_lock, x_sol, x_eol, x_vid, x_sec, x_msa, x_vbid});
                end
            end
            $fclose(fd);
            if (vec_test.size() == 0)
            begin
                $display("the test data file holds no vectors");
                load_ok = 1'b0;
            end
        end
        load_done = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [7:0] exp_v,
                               input logic [7:0] act_v);
        checks++;
        if (act_v !== exp_v)
        begin
            errors++;
            test_errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_outputs(input int i);
        logic [12:0] e;
        e = vec_exp[i];
        // Pass-through follows the inputs of the same cycle
        check_value("src_k", vec_k[i], src_k);
        check_value("src_dat[0]", vec_d0[i], src_dat[0]);
        check_value("src_dat[1]", vec_d1[i], src_dat[1]);
        check_value("src_lock", e[12], src_lock);
        check_value("src_sol", e[11:10], src_sol);
        check_value("src_eol", e[9:8], src_eol);
        check_value("src_vid", e[7:6], src_vid);
        check_value("src_sec", e[5:4], src_sec);
        check_value("src_msa", e[3:2], src_msa);
        check_value("src_vbid", e[1:0], src_vbid);
    endtask

    task automatic report_test(input int tnum, input int ncyc);
        tests_run++;
        if (test_errors == 0)
            $display("test %0d: %0d cycles, ok", tnum, ncyc);
        else
        begin
            tests_failed++;
            $display("test %0d: %0d cycles, %0d mismatches", tnum, ncyc, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_vectors();
        int cur;
        int ncyc;
        cur = vec_test[0];
        ncyc = 0;
        for (int i = 0; i < vec_test.size(); i++)
        begin
            if (vec_test[i] != cur)
            begin
                report_test(cur, ncyc);
                cur = vec_test[i];
                ncyc = 0;
            end
            @(posedge CLK_IN);
            lnk_lock <= vec_lock[i];
            ctl_efm  <= vec_efm[i];
            lnk_k    <= vec_k[i];
            lnk_dat  <= {vec_d1[i], vec_d0[i]};
            // Outputs settle well before the falling edge
            @(negedge CLK_IN);
            check_outputs(i);
            ncyc++;
        end
        report_test(cur, ncyc);
    endtask

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        RST_IN   = 1'b1;
        lnk_lock = 1'b0;
        ctl_efm  = 1'b0;
        lnk_k    = '0;
        lnk_dat  = '0;
        load_vectors();
        if (!load_ok)
            failed = 1'b1;
        else
        begin
            repeat (4) @(posedge CLK_IN);
            RST_IN <= 1'b0;
            run_vectors();
            failed = (errors != 0) || (tests_failed != 0);
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (failed)
            $display("TEST FAIL");
        else
            $display("TEST PASS");
        $finish;
    end

    // Reset, every vector and some margin
    initial
    begin
        wait (load_done);
        #((vec_test.size() + 20) * 10);
        $display("timeout: the run did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== testbench/dprx_testdata.txt ====
# test lock efm k d0 d1, then src_lock sol eol vid sec msa vbid expected in that cycle
# Two-bit fields list sublane 1 first, bytes in hex, rr takes a byte from the LFSR
# Lock low, nothing flagged
1 0 0 00 rr rr 0 00 00 00 00 00 00
1 0 0 01 bc rr 0 00 00 00 00 00 00
1 1 0 00 rr rr 0 00 00 00 00 00 00
# BE then pixels, BS in sublane 1 ends the run
2 1 0 00 rr rr 1 00 00 00 00 00 00
2 1 0 01 fb rr 1 01 00 00 00 00 00
2 1 0 00 rr rr 1 00 00 10 00 00 00
2 1 0 00 rr rr 1 00 00 11 00 00 00
2 1 0 10 rr bc 1 00 00 11 00 00 00
2 1 0 00 rr rr 1 00 01 01 00 00 00
# Normal framing BS in sublane 0
3 1 0 01 bc rr 1 00 10 00 00 00 01
3 1 0 00 rr rr 1 00 00 00 00 00 10
3 1 1 00 rr rr 1 00 00 00 00 00 00
# Enhanced framing, both alignments, then a lone BS
4 1 1 11 bc 7c 1 00 10 00 00 00 00
4 1 1 11 7c bc 1 00 00 00 00 00 00
4 1 1 00 rr rr 1 00 00 00 00 00 00
4 1 1 00 rr rr 1 00 00 00 00 00 01
4 1 1 10 rr bc 1 00 00 00 00 00 00
4 1 1 11 7c 7c 1 00 01 00 00 00 00
4 1 1 01 bc rr 1 00 00 00 00 00 00
4 1 1 00 rr rr 1 00 00 00 00 00 10
4 1 1 01 bc rr 1 00 00 00 00 00 00
4 1 1 00 rr rr 1 00 00 00 00 00 00
4 1 1 00 rr rr 1 00 00 00 00 00 00
# MSA packet, then a secondary packet
5 1 0 11 5c 5c 1 00 00 00 00 00 00
5 1 0 00 rr rr 1 00 00 00 00 00 00
5 1 0 00 rr rr 1 00 00 00 00 11 00
5 1 0 10 rr fd 1 00 00 00 00 11 00
5 1 0 00 rr rr 1 00 00 00 00 01 00
5 1 0 00 rr rr 1 00 00 00 00 00 00
5 1 0 10 rr 5c 1 00 00 00 00 00 00
5 1 0 00 rr rr 1 00 00 00 00 00 00
5 1 0 01 fd rr 1 00 00 00 11 00 00
5 1 0 00 rr rr 1 00 00 00 00 00 00
# Lock lost during video and a packet
6 1 0 10 rr fb 1 10 00 00 00 00 00
6 1 0 01 5c rr 1 00 00 00 00 00 00
6 1 0 00 rr rr 1 00 00 11 10 00 00
6 0 0 00 rr rr 1 00 00 11 11 00 00
6 0 0 00 rr rr 0 00 00 11 11 00 00
6 0 0 00 rr rr 0 00 00 00 00 00 00
6 1 0 00 rr rr 0 00 00 00 00 00 00
6 1 0 00 rr rr 1 00 00 00 00 00 00

// ==== list.f ====
+incdir+include
verilog/dprx_pkg.sv
verilog/dprx_sym_detect.sv
verilog/dprx_vid_track.sv
verilog/dprx_sdp_track.sv
verilog/dprx_blank_decode.sv
verilog/dprx_parser.sv
testbench/tb_dprx_parser.sv
